/* design/pod_macros.svh */
////////////////////////////////////////////////////////////////////////////
// pod dimensions, coordinate widths, bank address and data sizes
////////////////////////////////////////////////////////////////////////////

`ifndef POD_MACROS_SVH
`define POD_MACROS_SVH

// tile array shape
`define POD_COLS       4
`define POD_TILE_ROWS  2

// coordinates, host column is x 0
`define POD_X_W        3
`define POD_Y_W        2

// vcache bank geometry
`define POD_ADDR_W     4
`define POD_DATA_W     32
`define POD_BANK_WORDS 16

`endif

/* design/pod_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// opcode and port enums, packet and forward link structs
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pod_macros.svh"

package pod_pkg;

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_STORE,
    OP_RESP
  } op_e;

  // router ports, also used as array index
  typedef enum logic [1:0] {
    DIR_N,
    DIR_S,
    DIR_E,
    DIR_W
  } dir_e;

  // 48 bit packet
  typedef struct packed {
    op_e                    op;
    logic [`POD_X_W-1:0]    dst_x;
    logic [`POD_Y_W-1:0]    dst_y;
    logic [`POD_X_W-1:0]    src_x;
    logic [`POD_Y_W-1:0]    src_y;
    logic [`POD_ADDR_W-1:0] addr;
    logic [`POD_DATA_W-1:0] data;
  } pkt_s;

  // ready goes back on its own wire
  typedef struct packed {
    logic valid;
    pkt_s pkt;
  } link_s;

endpackage

`default_nettype wire

/* design/mesh_router.sv */
////////////////////////////////////////////////////////////////////////////
// X-Y mesh router, one-entry input buffers, round-robin per output
// also holds one stage of the row-by-row reset pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module mesh_router
  import pod_pkg::*;
  #(parameter int my_x_p = 1
    , parameter int my_y_p = 1
  )
  (
    input  logic clk_i
    , input  logic reset_i
    , output logic reset_o

    , input  link_s [DIR_W:DIR_N] link_i
    , output logic  [DIR_W:DIR_N] ready_o

    , output link_s [DIR_W:DIR_N] link_o
    , input  logic  [DIR_W:DIR_N] ready_i
  );

  localparam logic [`POD_X_W-1:0] my_x_lp = `POD_X_W'(my_x_p);
  localparam logic [`POD_Y_W-1:0] my_y_lp = `POD_Y_W'(my_y_p);

  logic reset_r;

  logic [DIR_W:DIR_N] buf_v_r;
  logic [DIR_W:DIR_N] buf_v_n;
  pkt_s [DIR_W:DIR_N] buf_pkt_r;
  dir_e [DIR_W:DIR_N] route;

  // [output][input]
  logic [DIR_W:DIR_N][3:0] req;
  logic [DIR_W:DIR_N][3:0] gnt;
  logic [DIR_W:DIR_N][1:0] ptr_r;
  logic [DIR_W:DIR_N][1:0] ptr_n;

  logic [DIR_W:DIR_N] accept;
  logic [DIR_W:DIR_N] drain;

  // this router's reset stage, next row sees it a cycle later
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  assign reset_o = reset_r;

  // hosts hang off column 1, so x 0 is steered like column 1
  // until the packet is on the host's row
  function automatic dir_e route_f(pkt_s p);
    logic [`POD_X_W-1:0] eff_x;
    eff_x = (p.dst_x == '0) ? `POD_X_W'(1) : p.dst_x;
    if (eff_x > my_x_lp) begin
      route_f = DIR_E;
    end else if (eff_x < my_x_lp) begin
      route_f = DIR_W;
    end else if (p.dst_y > my_y_lp) begin
      route_f = DIR_S;
    end else if (p.dst_y < my_y_lp) begin
      route_f = DIR_N;
    end else begin
      route_f = DIR_W;
    end
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      route[i] = route_f(buf_pkt_r[i]);
    end
  end

  // requests, no u-turns
  always_comb begin
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 4; i++) begin
        req[o][i] = buf_v_r[i] && (route[i] == dir_e'(o)) && (i != o);
      end
    end
  end

  // round-robin from ptr, first requester wins
  always_comb begin
    logic [1:0] idx;
    gnt = '0;
    for (int o = 0; o < 4; o++) begin
      for (int k = 0; k < 4; k++) begin
        idx = ptr_r[o] + 2'(k);
        if (req[o][idx] && (gnt[o] == '0)) begin
          gnt[o][idx] = 1'b1;
        end
      end
    end
  end

  // a stalled winner keeps top priority so its offer stays stable
  always_comb begin
    for (int o = 0; o < 4; o++) begin
      ptr_n[o] = ptr_r[o];
      for (int i = 0; i < 4; i++) begin
        if (gnt[o][i]) begin
          ptr_n[o] = ready_i[o] ? 2'(i + 1) : 2'(i);
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < 4; o++) begin
      link_o[o].valid = |gnt[o];
      link_o[o].pkt = '0;
      for (int i = 0; i < 4; i++) begin
        if (gnt[o][i]) begin
          link_o[o].pkt = buf_pkt_r[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      accept[i] = link_i[i].valid & ready_o[i];
      drain[i] = 1'b0;
      for (int o = 0; o < 4; o++) begin
        drain[i] = drain[i] | (gnt[o][i] & ready_i[o]);
      end
    end
  end

  assign buf_v_n = (buf_v_r & ~drain) | accept;

  always_ff @(posedge clk_i) begin
    if (reset_r) begin
      buf_v_r <= '0;
      ready_o <= '0;
      ptr_r <= '0;
    end else begin
      buf_v_r <= buf_v_n;
      ready_o <= ~buf_v_n;
      ptr_r <= ptr_n;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 4; i++) begin
      if (accept[i]) begin
        buf_pkt_r[i] <= link_i[i].pkt;
      end
    end
  end

endmodule

`default_nettype wire

/* design/vcache_bank.sv */
////////////////////////////////////////////////////////////////////////////
// vcache bank as a plain word memory, one request in service at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module vcache_bank
  import pod_pkg::*;
  #(parameter int my_x_p = 1
    , parameter int my_y_p = 0
  )
  (
    input  logic clk_i
    , input  logic reset_i

    , input  link_s req_i
    , output logic  req_ready_o

    , output link_s resp_o
    , input  logic  resp_ready_i
  );

  localparam logic [`POD_X_W-1:0] my_x_lp = `POD_X_W'(my_x_p);
  localparam logic [`POD_Y_W-1:0] my_y_lp = `POD_Y_W'(my_y_p);

  logic [`POD_DATA_W-1:0] mem_r [0:`POD_BANK_WORDS-1];

  logic resp_v_r;
  logic resp_v_n;
  pkt_s resp_pkt_r;
  logic accept;
  logic resp_done;
  logic is_store;

  assign accept = req_i.valid & req_ready_o;
  assign resp_done = resp_v_r & resp_ready_i;
  assign resp_v_n = (resp_v_r & ~resp_done) | accept;
  assign is_store = (req_i.pkt.op == OP_STORE);

  // ready drops while a response is pending
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
      req_ready_o <= 1'b0;
    end else begin
      resp_v_r <= resp_v_n;
      req_ready_o <= ~resp_v_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_store) begin
      mem_r[req_i.pkt.addr] <= req_i.pkt.data;
    end
  end

  // response goes back to the requester
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_pkt_r.op <= OP_RESP;
      resp_pkt_r.dst_x <= req_i.pkt.src_x;
      resp_pkt_r.dst_y <= req_i.pkt.src_y;
      resp_pkt_r.src_x <= my_x_lp;
      resp_pkt_r.src_y <= my_y_lp;
      resp_pkt_r.addr <= req_i.pkt.addr;
      // store answers with zero data
      resp_pkt_r.data <= is_store ? '0 : mem_r[req_i.pkt.addr];
    end
  end

  assign resp_o.valid = resp_v_r;
  assign resp_o.pkt = resp_pkt_r;

endmodule

`default_nettype wire

/* design/tile_array.sv */
////////////////////////////////////////////////////////////////////////////
// rows and columns of mesh routers, neighbor links, edge ports
// and the row-to-row reset chain
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module tile_array
  import pod_pkg::*;
  (
    input  logic clk_i
    , input  logic reset_i
    , output logic reset_o

    , input  link_s [`POD_TILE_ROWS-1:0] west_link_i
    , output logic  [`POD_TILE_ROWS-1:0] west_ready_o
    , output link_s [`POD_TILE_ROWS-1:0] west_link_o
    , input  logic  [`POD_TILE_ROWS-1:0] west_ready_i

    , input  link_s [`POD_COLS-1:0] north_link_i
    , output logic  [`POD_COLS-1:0] north_ready_o
    , output link_s [`POD_COLS-1:0] north_link_o
    , input  logic  [`POD_COLS-1:0] north_ready_i

    , input  link_s [`POD_COLS-1:0] south_link_i
    , output logic  [`POD_COLS-1:0] south_ready_o
    , output link_s [`POD_COLS-1:0] south_link_o
    , input  logic  [`POD_COLS-1:0] south_ready_i
  );

  localparam int rows_lp = `POD_TILE_ROWS;
  localparam int cols_lp = `POD_COLS;

  link_s [rows_lp-1:0][cols_lp-1:0][DIR_W:DIR_N] rtr_link_li;
  link_s [rows_lp-1:0][cols_lp-1:0][DIR_W:DIR_N] rtr_link_lo;
  logic  [rows_lp-1:0][cols_lp-1:0][DIR_W:DIR_N] rtr_ready_li;
  logic  [rows_lp-1:0][cols_lp-1:0][DIR_W:DIR_N] rtr_ready_lo;
  logic  [rows_lp-1:0][cols_lp-1:0] rtr_reset_li;
  logic  [rows_lp-1:0][cols_lp-1:0] rtr_reset_lo;

  for (genvar r = 0; r < rows_lp; r++) begin : row
    for (genvar c = 0; c < cols_lp; c++) begin : col
      mesh_router #(
        .my_x_p(c + 1)
        , .my_y_p(r + 1)
      ) rtr (
        .clk_i(clk_i)
        , .reset_i(rtr_reset_li[r][c])
        , .reset_o(rtr_reset_lo[r][c])
        , .link_i(rtr_link_li[r][c])
        , .ready_o(rtr_ready_lo[r][c])
        , .link_o(rtr_link_lo[r][c])
        , .ready_i(rtr_ready_li[r][c])
      );

      // first row faces the north banks
      if (r == 0) begin
        assign rtr_reset_li[r][c] = reset_i;
        assign rtr_link_li[r][c][DIR_N] = north_link_i[c];
        assign rtr_ready_li[r][c][DIR_N] = north_ready_i[c];
        assign north_link_o[c] = rtr_link_lo[r][c][DIR_N];
        assign north_ready_o[c] = rtr_ready_lo[r][c][DIR_N];
      end else begin
        assign rtr_reset_li[r][c] = rtr_reset_lo[r-1][c];
        assign rtr_link_li[r][c][DIR_N] = rtr_link_lo[r-1][c][DIR_S];
        assign rtr_ready_li[r][c][DIR_N] = rtr_ready_lo[r-1][c][DIR_S];
      end

      // last row faces the south banks
      if (r == rows_lp - 1) begin
        assign rtr_link_li[r][c][DIR_S] = south_link_i[c];
        assign rtr_ready_li[r][c][DIR_S] = south_ready_i[c];
        assign south_link_o[c] = rtr_link_lo[r][c][DIR_S];
        assign south_ready_o[c] = rtr_ready_lo[r][c][DIR_S];
      end else begin
        assign rtr_link_li[r][c][DIR_S] = rtr_link_lo[r+1][c][DIR_N];
        assign rtr_ready_li[r][c][DIR_S] = rtr_ready_lo[r+1][c][DIR_N];
      end

      // host side
      if (c == 0) begin
        assign rtr_link_li[r][c][DIR_W] = west_link_i[r];
        assign rtr_ready_li[r][c][DIR_W] = west_ready_i[r];
        assign west_link_o[r] = rtr_link_lo[r][c][DIR_W];
        assign west_ready_o[r] = rtr_ready_lo[r][c][DIR_W];
      end else begin
        assign rtr_link_li[r][c][DIR_W] = rtr_link_lo[r][c-1][DIR_E];
        assign rtr_ready_li[r][c][DIR_W] = rtr_ready_lo[r][c-1][DIR_E];
      end

      // east edge tied off, nothing routes past the last column
      if (c == cols_lp - 1) begin
        assign rtr_link_li[r][c][DIR_E] = '0;
        assign rtr_ready_li[r][c][DIR_E] = 1'b0;
      end else begin
        assign rtr_link_li[r][c][DIR_E] = rtr_link_lo[r][c+1][DIR_W];
        assign rtr_ready_li[r][c][DIR_E] = rtr_ready_lo[r][c+1][DIR_W];
      end
    end
  end

  // all columns carry the same reset
  assign reset_o = |rtr_reset_lo[rows_lp-1];

endmodule

`default_nettype wire

/* design/manycore_pod.sv */
////////////////////////////////////////////////////////////////////////////
// pod top with north banks, tile array, south banks and west host links
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module manycore_pod
  import pod_pkg::*;
  (
    input  logic clk_i
    , input  logic reset_i

    , input  link_s [`POD_TILE_ROWS-1:0] west_link_i
    , output logic  [`POD_TILE_ROWS-1:0] west_ready_o
    , output link_s [`POD_TILE_ROWS-1:0] west_link_o
    , input  logic  [`POD_TILE_ROWS-1:0] west_ready_i
  );

  localparam int cols_lp = `POD_COLS;
  localparam int south_y_lp = `POD_TILE_ROWS + 1;

  logic reset_r;
  logic tile_reset_lo;

  // tile array side of the bank links
  link_s [cols_lp-1:0] north_req_lo;
  logic  [cols_lp-1:0] north_req_ready_li;
  link_s [cols_lp-1:0] north_resp_li;
  logic  [cols_lp-1:0] north_resp_ready_lo;

  link_s [cols_lp-1:0] south_req_lo;
  logic  [cols_lp-1:0] south_req_ready_li;
  link_s [cols_lp-1:0] south_resp_li;
  logic  [cols_lp-1:0] south_resp_ready_lo;

  // north bank row reset stage
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  for (genvar c = 0; c < cols_lp; c++) begin : north_bank
    vcache_bank #(
      .my_x_p(c + 1)
      , .my_y_p(0)
    ) bank (
      .clk_i(clk_i)
      , .reset_i(reset_r)
      , .req_i(north_req_lo[c])
      , .req_ready_o(north_req_ready_li[c])
      , .resp_o(north_resp_li[c])
      , .resp_ready_i(north_resp_ready_lo[c])
    );
  end

  tile_array tiles (
    .clk_i(clk_i)
    , .reset_i(reset_r)
    , .reset_o(tile_reset_lo)

    , .west_link_i(west_link_i)
    , .west_ready_o(west_ready_o)
    , .west_link_o(west_link_o)
    , .west_ready_i(west_ready_i)

    , .north_link_i(north_resp_li)
    , .north_ready_o(north_resp_ready_lo)
    , .north_link_o(north_req_lo)
    , .north_ready_i(north_req_ready_li)

    , .south_link_i(south_resp_li)
    , .south_ready_o(south_resp_ready_lo)
    , .south_link_o(south_req_lo)
    , .south_ready_i(south_req_ready_li)
  );

  // south banks reset last, off the bottom tile row
  for (genvar c = 0; c < cols_lp; c++) begin : south_bank
    vcache_bank #(
      .my_x_p(c + 1)
      , .my_y_p(south_y_lp)
    ) bank (
      .clk_i(clk_i)
      , .reset_i(tile_reset_lo)
      , .req_i(south_req_lo[c])
      , .req_ready_o(south_req_ready_li[c])
      , .resp_o(south_resp_li[c])
      , .resp_ready_i(south_resp_ready_lo[c])
    );
  end

endmodule

`default_nettype wire

/* tests/manycore_pod_sva.sv */
////////////////////////////////////////////////////////////////////////////
// protocol assertions on the west host links, bound into manycore_pod
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module manycore_pod_sva
  import pod_pkg::*;
  (
    input  logic clk_i
    , input  logic reset_i
    , input  link_s [`POD_TILE_ROWS-1:0] req_link_i
    , input  logic  [`POD_TILE_ROWS-1:0] req_ready_i
    , input  link_s [`POD_TILE_ROWS-1:0] resp_link_i
    , input  logic  [`POD_TILE_ROWS-1:0] resp_ready_i
  );

  // cycles of reset seen so far, routers clear once the chain reaches them
  logic [2:0] reset_cycles_r = '0;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reset_cycles_r <= '0;
    end else if (reset_cycles_r != 3'd7) begin
      reset_cycles_r <= reset_cycles_r + 3'd1;
    end
  end

  for (genvar r = 0; r < `POD_TILE_ROWS; r++) begin : row
    resp_idle_in_reset: assert property (@(posedge clk_i)
      (reset_i && reset_cycles_r >= 3'd4) |-> !resp_link_i[r].valid)
      else $error("response valid on host row %0d while reset is high", r);

    resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (resp_link_i[r].valid && !resp_ready_i[r])
        |=> (resp_link_i[r].valid && $stable(resp_link_i[r].pkt)))
      else $error("response on host row %0d changed before it was taken", r);

    req_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (req_link_i[r].valid && !req_ready_i[r])
        |=> (req_link_i[r].valid && $stable(req_link_i[r].pkt)))
      else $error("request on host row %0d changed before it was taken", r);

    // no x on valid once out of reset
    resp_valid_known: assert property (@(posedge clk_i) disable iff (reset_i)
      !$isunknown(resp_link_i[r].valid))
      else $error("response valid on host row %0d is unknown", r);

    req_valid_known: assert property (@(posedge clk_i) disable iff (reset_i)
      !$isunknown(req_link_i[r].valid))
      else $error("request valid on host row %0d is unknown", r);
  end

endmodule

`default_nettype wire

/* tests/manycore_pod_tb.sv */
////////////////////////////////////////////////////////////////////////////
// pod testbench with clock, reset, request table, host drivers,
// response checker and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pod_macros.svh"

module manycore_pod_tb
  import pod_pkg::*;
  ();

  localparam int rows_lp = `POD_TILE_ROWS;
  localparam int reset_cycles_lp = 5;
  localparam int reset_time_lp = 8;
  localparam int cycles_per_req_lp = 40;
  localparam int extra_reqs_lp = 6;
  localparam int resp_wait_lp = 40;
  localparam logic [31:0] seed_lp = 32'hd5c19cfb;

  typedef struct {
    int row;
    op_e op;
    int col;
    bit south;
    logic [`POD_ADDR_W-1:0] addr;
    logic [`POD_DATA_W-1:0] data;
  } entry_s;

  logic clk_i;
  logic reset_i;
  link_s [rows_lp-1:0] west_link_i;
  logic  [rows_lp-1:0] west_ready_o;
  link_s [rows_lp-1:0] west_link_o;
  logic  [rows_lp-1:0] west_ready_i;

  entry_s table_q[$];
  logic [31:0] lcg_state = seed_lp;
  logic [`POD_DATA_W-1:0] model_mem [0:1][1:`POD_COLS][0:`POD_BANK_WORDS-1];
  pkt_s resp_pkt [0:rows_lp-1];
  int resp_cnt [0:rows_lp-1];
  int seen [0:rows_lp-1];
  int mismatch_cnt = 0;
  int fail_cnt = 0;

  manycore_pod UUT (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .west_link_i(west_link_i)
    , .west_ready_o(west_ready_o)
    , .west_link_o(west_link_o)
    , .west_ready_i(west_ready_i)
  );

  bind manycore_pod manycore_pod_sva sva (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .req_link_i(west_link_i)
    , .req_ready_i(west_ready_o)
    , .resp_link_i(west_link_o)
    , .resp_ready_i(west_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // one transfer per negedge that sees valid and ready
  always @(negedge clk_i) begin
    for (int r = 0; r < rows_lp; r++) begin
      if (west_link_o[r].valid === 1'b1 && west_ready_i[r] === 1'b1) begin
        resp_pkt[r] <= west_link_o[r].pkt;
        resp_cnt[r] <= resp_cnt[r] + 1;
      end
    end
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic entry_s make_entry(int row, op_e op, int col, bit south, int addr);
    entry_s e;
    e.row = row;
    e.op = op;
    e.col = col;
    e.south = south;
    e.addr = `POD_ADDR_W'(addr);
    e.data = '0;
    if (op == OP_STORE) begin
      lcg_state = lcg_next(lcg_state);
      e.data = lcg_state;
    end
    return e;
  endfunction

  // host sits at x 0 and tile row r has y r+1
  function automatic pkt_s make_req(entry_s e);
    pkt_s p;
    p.op = e.op;
    p.dst_x = `POD_X_W'(e.col);
    p.dst_y = e.south ? `POD_Y_W'(rows_lp + 1) : '0;
    p.src_x = '0;
    p.src_y = `POD_Y_W'(e.row + 1);
    p.addr = e.addr;
    p.data = e.data;
    return p;
  endfunction

  task automatic check_field(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idle(bit ready_too);
    for (int r = 0; r < rows_lp; r++) begin
      check_field($sformatf("west_link_o[%0d].valid", r), west_link_o[r].valid, 1'b0);
      if (ready_too) begin
        check_field($sformatf("west_ready_o[%0d]", r), west_ready_o[r], 1'b0);
      end
    end
  endtask

  task automatic check_resp(int row, int col, bit south, logic [31:0] exp_data, pkt_s p);
    string n;
    n = $sformatf("west_link_o[%0d].pkt", row);
    check_field({n, ".op"}, p.op, OP_RESP);
    check_field({n, ".dst_x"}, p.dst_x, 0);
    check_field({n, ".dst_y"}, p.dst_y, row + 1);
    check_field({n, ".src_x"}, p.src_x, col);
    check_field({n, ".src_y"}, p.src_y, south ? rows_lp + 1 : 0);
    check_field({n, ".data"}, p.data, exp_data);
  endtask

  task automatic send_req(int row, pkt_s p);
    link_s l;
    l.valid = 1'b1;
    l.pkt = p;
    @(posedge clk_i);
    west_link_i[row] <= l;
    @(negedge clk_i);
    while (west_ready_o[row] !== 1'b1) @(negedge clk_i);
    @(posedge clk_i);
    west_link_i[row] <= '0;
  endtask

  task automatic wait_resp(int row, output pkt_s p, output bit ok);
    int k;
    k = 0;
    while (resp_cnt[row] == seen[row] && k < resp_wait_lp) begin
      @(negedge clk_i);
      k++;
    end
    ok = (resp_cnt[row] != seen[row]);
    p = resp_pkt[row];
    assert (ok) else begin
      fail_cnt++;
      $display("no response reached host row %0d within %0d cycles", row, k);
    end
    seen[row] = resp_cnt[row];
  endtask

  task automatic apply_entry(entry_s e);
    pkt_s r;
    bit ok;
    logic [31:0] exp;
    if (e.op == OP_STORE) begin
      model_mem[e.south][e.col][e.addr] = e.data;
      exp = '0;
    end else begin
      exp = model_mem[e.south][e.col][e.addr];
    end
    send_req(e.row, make_req(e));
    wait_resp(e.row, r, ok);
    if (ok) begin
      check_resp(e.row, e.col, e.south, exp, r);
    end
  endtask

  task automatic build_table();
    table_q.push_back(make_entry(0, OP_STORE, 1, 1'b0, 3));
    table_q.push_back(make_entry(0, OP_LOAD, 1, 1'b0, 3));
    table_q.push_back(make_entry(0, OP_STORE, 1, 1'b1, 3));
    table_q.push_back(make_entry(0, OP_LOAD, 1, 1'b1, 3));
    table_q.push_back(make_entry(0, OP_LOAD, 1, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_STORE, 3, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_LOAD, 3, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_LOAD, 1, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_STORE, 4, 1'b1, 9));
    table_q.push_back(make_entry(0, OP_LOAD, 4, 1'b1, 9));
    table_q.push_back(make_entry(0, OP_STORE, 1, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_LOAD, 1, 1'b0, 3));
    table_q.push_back(make_entry(1, OP_STORE, 2, 1'b1, 15));
    table_q.push_back(make_entry(1, OP_LOAD, 2, 1'b1, 15));
  endtask

  // host 0 stalls a load response which must hold and then arrive once
  task automatic backpressure_test();
    entry_s ld;
    pkt_s held;
    int base;
    int k;
    apply_entry(make_entry(0, OP_STORE, 2, 1'b0, 5));
    ld = make_entry(0, OP_LOAD, 2, 1'b0, 5);
    @(posedge clk_i);
    west_ready_i[0] <= 1'b0;
    base = resp_cnt[0];
    send_req(0, make_req(ld));
    k = 0;
    @(negedge clk_i);
    while (west_link_o[0].valid !== 1'b1 && k < resp_wait_lp) begin
      @(negedge clk_i);
      k++;
    end
    assert (west_link_o[0].valid === 1'b1) else begin
      fail_cnt++;
      $display("stalled load response never became valid on host row 0");
    end
    held = west_link_o[0].pkt;
    repeat (6) begin
      @(negedge clk_i);
      check_field("west_link_o[0].valid", west_link_o[0].valid, 1'b1);
      check_field("west_link_o[0].pkt", west_link_o[0].pkt, held);
    end
    @(posedge clk_i);
    west_ready_i[0] <= 1'b1;
    repeat (8) @(negedge clk_i);
    assert (resp_cnt[0] == base + 1) else begin
      fail_cnt++;
      $display("stalled response arrived %0d times instead of once", resp_cnt[0] - base);
    end
    seen[0] = resp_cnt[0];
    check_resp(0, ld.col, ld.south, model_mem[0][2][5], resp_pkt[0]);
  endtask

  // both rows at once with each answer matched by its bank coordinate
  task automatic concurrent_test();
    entry_s a;
    entry_s b;
    a = make_entry(0, OP_STORE, 2, 1'b1, 7);
    b = make_entry(1, OP_STORE, 3, 1'b0, 7);
    fork
      apply_entry(a);
      apply_entry(b);
    join
    a = make_entry(0, OP_LOAD, 2, 1'b1, 7);
    b = make_entry(1, OP_LOAD, 3, 1'b0, 7);
    fork
      apply_entry(a);
      apply_entry(b);
    join
  endtask

  task automatic watchdog(int cycles);
    repeat (cycles) @(posedge clk_i);
    $display("run stopped after %0d cycles waiting for the pod", cycles);
    $display("Regression failed");
    $finish;
  endtask

  initial begin
    int timeout_cycles;
    reset_i = 1'b1;
    west_link_i = '0;
    west_ready_i = '1;
    build_table();
    timeout_cycles = (table_q.size() + extra_reqs_lp) * cycles_per_req_lp + reset_time_lp;
    fork
      watchdog(timeout_cycles);
    join_none

    // valid stays low once the reset chain has reached each row
    // ready also low through the first cycle after reset
    for (int k = 1; k <= reset_time_lp; k++) begin
      @(posedge clk_i);
      if (k == reset_cycles_lp) begin
        reset_i <= 1'b0;
      end
      @(negedge clk_i);
      if (k >= 4) begin
        check_idle(k <= reset_cycles_lp + 1);
      end
    end

    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    backpressure_test();
    concurrent_test();
    repeat (4) @(posedge clk_i);

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/pod_pkg.sv
design/mesh_router.sv
design/vcache_bank.sv
design/tile_array.sv
design/manycore_pod.sv
tests/manycore_pod_sva.sv
tests/manycore_pod_tb.sv
